// File: Bender.yml
package:
  name: rvcore

sources:
  - include_dirs:
      - common
    files:
      - common/rvCorePkg.sv
      - design/controlUnit.sv
      - design/aluUnit.sv
      - design/regFile.sv
      - design/immExtend.sv
      - design/pcUnit.sv
      - design/rvCore.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/rvCoreTb.sv

// File: common/rvCorePkg.sv
package rvCorePkg;

    // ALU operations
    typedef enum logic [3:0] {
        ADD   = 4'b0000,
        SUB   = 4'b0001,
        AND   = 4'b0010,
        OR    = 4'b0011,
        XOR   = 4'b0100,
        SLL   = 4'b0101,
        SRL   = 4'b0110,
        SRA   = 4'b0111,
        SLT   = 4'b1000,
        SLTU  = 4'b1001,
        PASSB = 4'b1010
    } aluOp_t;

    // Immediate formats
    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b010,
        IMM_B = 3'b011,
        IMM_U = 3'b100,
        IMM_J = 3'b101
    } immKind_t;

    // Write-back sources
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } resultSrc_t;

endpackage

// File: common/rvCore_defs.svh
`ifndef RVCORE_DEFS_SVH
`define RVCORE_DEFS_SVH

// Data and address width
`define XLEN 32

// Architectural registers
`define REG_COUNT 32

`define RESET_PC 32'h0000_0000

`endif

// File: design/aluUnit.sv
`include "rvCore_defs.svh"

module aluUnit import rvCorePkg::*; (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  aluOp_t           aluOp,
    output logic [`XLEN-1:0] result,
    output logic             zero,
    output logic             less,
    output logic             lessU
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // Flags compare a with b whatever the operation
    assign zero  = (a == b);
    assign less  = ($signed(a) < $signed(b));
    assign lessU = (a < b);

    always_comb begin
        case (aluOp)
            ADD:   result = a + b;
            SUB:   result = a - b;
            AND:   result = a & b;
            OR:    result = a | b;
            XOR:   result = a ^ b;
            SLL:   result = a << shamt;
            SRL:   result = a >> shamt;
            SRA:   result = $unsigned($signed(a) >>> shamt);
            SLT:   result = {{(`XLEN-1){1'b0}}, less};
            SLTU:  result = {{(`XLEN-1){1'b0}}, lessU};
            // LUI goes straight through
            PASSB: result = b;
            default: result = a + b;
        endcase
    end

endmodule

// File: design/controlUnit.sv
`include "rvCore_defs.svh"

module controlUnit import rvCorePkg::*; (
    input  logic [`XLEN-1:0] instr,
    input  logic             zero,
    input  logic             less,
    input  logic             lessU,
    output aluOp_t           aluOp,
    output immKind_t         immKind,
    output resultSrc_t       resultSrc,
    output logic             aluSrcImm,
    output logic             aluSrcPc,
    output logic             regWrite,
    output logic             memWrite,
    output logic             jump,
    output logic             jumpReg,
    output logic             branchTaken
);

    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       illegal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        aluOp       = ADD;
        immKind     = IMM_I;
        resultSrc   = RES_ALU;
        aluSrcImm   = 1'b0;
        aluSrcPc    = 1'b0;
        regWrite    = 1'b0;
        memWrite    = 1'b0;
        jump        = 1'b0;
        jumpReg     = 1'b0;
        branchTaken = 1'b0;
        illegal     = 1'b0;

        case (opcode)
            opReg: begin
                regWrite = 1'b1;
                case (funct3)
                    3'b000: aluOp = (funct7[5]) ? SUB : ADD;
                    3'b001: aluOp = SLL;
                    3'b010: aluOp = SLT;
                    // Unsigned compare
                    3'b011: aluOp = SLTU;
                    3'b100: aluOp = XOR;
                    3'b101: aluOp = (funct7[5]) ? SRA : SRL;
                    3'b110: aluOp = OR;
                    default: aluOp = AND;
                endcase
                // Only SUB and SRA may carry the alternate funct7
                if (funct7 == 7'h20) begin
                    illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                end else if (funct7 != 7'h00) begin
                    illegal = 1'b1;
                end
            end

            opImm: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                case (funct3)
                    3'b000: aluOp = ADD;
                    3'b001: begin
                        aluOp   = SLL;
                        illegal = (funct7 != 7'h00);
                    end
                    3'b010: aluOp = SLT;
                    3'b011: aluOp = SLTU;
                    3'b100: aluOp = XOR;
                    3'b101: begin
                        aluOp   = (funct7[5]) ? SRA : SRL;
                        illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
                    end
                    3'b110: aluOp = OR;
                    default: aluOp = AND;
                endcase
            end

            // Word access only, funct3 not looked at
            opLoad: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                resultSrc = RES_MEM;
            end

            opStore: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                immKind   = IMM_S;
            end

            opLui: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = PASSB;
                immKind   = IMM_U;
            end

            // PC + upper immediate
            opAuipc: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluSrcPc  = 1'b1;
                immKind   = IMM_U;
            end

            opJal: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                immKind   = IMM_J;
                resultSrc = RES_PC4;
            end

            opJalr: begin
                regWrite  = 1'b1;
                jumpReg   = 1'b1;
                aluSrcImm = 1'b1;
                resultSrc = RES_PC4;
                illegal   = (funct3 != 3'b000);
            end

            // Compare rs1 against rs2, flags pick the outcome
            opBranch: begin
                aluOp   = SUB;
                immKind = IMM_B;
                case (funct3)
                    3'b000: branchTaken = zero;
                    3'b001: branchTaken = ~zero;
                    3'b100: branchTaken = less;
                    3'b101: branchTaken = ~less;
                    3'b110: branchTaken = lessU;
                    3'b111: branchTaken = ~lessU;
                    default: illegal = 1'b1;
                endcase
            end

            // Anything else runs as a no-op
            default: ;
        endcase

        if (illegal) begin
            regWrite    = 1'b0;
            memWrite    = 1'b0;
            jump        = 1'b0;
            jumpReg     = 1'b0;
            branchTaken = 1'b0;
        end
    end

    // Checked each time a new instruction shows up
    assert property (@(instr) !(memWrite && regWrite))
        else $error("controlUnit: store and register write decoded together");

endmodule

// File: design/immExtend.sv
`include "rvCore_defs.svh"

module immExtend import rvCorePkg::*; (
    input  logic [`XLEN-1:0] instr,
    input  immKind_t         immKind,
    output logic [`XLEN-1:0] imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immKind)
            IMM_S: begin
                imm = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};
            end
            // Branch offsets are in halfwords
            IMM_B: begin
                imm = {{(`XLEN-12){sign}}, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{(`XLEN-20){sign}}, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            // I format, also the fallback
            default: begin
                imm = {{(`XLEN-12){sign}}, instr[31:20]};
            end
        endcase
    end

endmodule

// File: design/pcUnit.sv
`include "rvCore_defs.svh"

module pcUnit (
    input  logic             clk,
    input  logic             arstN,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] aluResult,
    input  logic             jump,
    input  logic             jumpReg,
    input  logic             branchTaken,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] pcPlus4
);

    logic [`XLEN-1:0] pcNext;

    assign pcPlus4 = pc + `XLEN'd4;

    always_comb begin
        if (jumpReg) begin
            // JALR drops bit 0 of the sum
            pcNext = {aluResult[`XLEN-1:1], 1'b0};
        end else if (jump || branchTaken) begin
            pcNext = pc + imm;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("pcUnit: misaligned pc %h", pc);

endmodule

// File: design/regFile.sv
`include "rvCore_defs.svh"

module regFile (
    input  logic             clk,
    input  logic             arstN,
    input  logic [4:0]       rs1Addr,
    input  logic [4:0]       rs2Addr,
    input  logic [4:0]       rdAddr,
    input  logic [`XLEN-1:0] rdData,
    input  logic             regWrite,
    output logic [`XLEN-1:0] rs1Data,
    output logic [`XLEN-1:0] rs2Data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (rdAddr != 5'd0)) begin
            regs[rdAddr] <= rdData;
        end
    end

    // Asynchronous reads
    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

    // x0 stays zero through any write-back
    assert property (@(posedge clk) disable iff (!arstN)
        (rs1Addr == 5'd0) |-> (rs1Data == '0))
        else $error("regFile: x0 read nonzero on port 1");
    assert property (@(posedge clk) disable iff (!arstN)
        (rs2Addr == 5'd0) |-> (rs2Data == '0))
        else $error("regFile: x0 read nonzero on port 2");

endmodule

// File: design/rvCore.sv
`include "rvCore_defs.svh"

module rvCore import rvCorePkg::*; (
    input  logic             clk,
    input  logic             arstN,
    output logic [`XLEN-1:0] instrAddr,
    input  logic [`XLEN-1:0] instr,
    output logic [`XLEN-1:0] dataAddr,
    output logic [`XLEN-1:0] dataWdata,
    output logic             dataWe,
    input  logic [`XLEN-1:0] dataRdata
);

    aluOp_t           aluOp;
    immKind_t         immKind;
    resultSrc_t       resultSrc;
    logic             aluSrcImm;
    logic             aluSrcPc;
    logic             regWrite;
    logic             memWrite;
    logic             jump;
    logic             jumpReg;
    logic             branchTaken;
    logic             zero;
    logic             less;
    logic             lessU;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] aluA;
    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] aluResult;
    logic [`XLEN-1:0] rdData;

    controlUnit controlUnit_inst (
        .instr(instr), .zero(zero), .less(less), .lessU(lessU),
        .aluOp(aluOp), .immKind(immKind), .resultSrc(resultSrc),
        .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc), .regWrite(regWrite),
        .memWrite(memWrite), .jump(jump), .jumpReg(jumpReg),
        .branchTaken(branchTaken)
    );

    regFile regFile_inst (
        .clk(clk), .arstN(arstN),
        .rs1Addr(instr[19:15]), .rs2Addr(instr[24:20]), .rdAddr(instr[11:7]),
        .rdData(rdData), .regWrite(regWrite),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    immExtend immExtend_inst (.instr(instr), .immKind(immKind), .imm(imm));

    // Operand muxes, AUIPC takes the PC on side A
    assign aluA = aluSrcPc ? pc : rs1Data;
    assign aluB = aluSrcImm ? imm : rs2Data;

    aluUnit aluUnit_inst (
        .a(aluA), .b(aluB), .aluOp(aluOp),
        .result(aluResult), .zero(zero), .less(less), .lessU(lessU)
    );

    pcUnit pcUnit_inst (
        .clk(clk), .arstN(arstN), .imm(imm), .aluResult(aluResult),
        .jump(jump), .jumpReg(jumpReg), .branchTaken(branchTaken),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    always_comb begin
        case (resultSrc)
            RES_MEM: rdData = dataRdata;
            RES_PC4: rdData = pcPlus4;
            default: rdData = aluResult;
        endcase
    end

    assign instrAddr = pc;
    assign dataAddr  = aluResult;
    assign dataWdata = rs2Data;
    assign dataWe    = memWrite;

endmodule

// File: sim.f
+incdir+common
common/rvCorePkg.sv
design/controlUnit.sv
design/aluUnit.sv
design/regFile.sv
design/immExtend.sv
design/pcUnit.sv
design/rvCore.sv
test/rvCoreTb.sv

// File: test/rvCoreTb.sv
`include "rvCore_defs.svh"

module rvCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    // Opcodes for the instruction encoder
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;

    localparam logic [31:0] nop        = 32'h0000_0013;
    localparam logic [31:0] markerAddr = 32'h0000_03FC;
    localparam int          runLimit   = 2000;

    logic             clk;
    logic             arstN;
    logic [`XLEN-1:0] instrAddr;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] dataAddr;
    logic [`XLEN-1:0] dataWdata;
    logic [`XLEN-1:0] dataRdata;
    logic             dataWe;

    logic [31:0] rom [1024];
    logic [31:0] dmem [1024];
    logic [31:0] trace [$];
    logic [31:0] stAddr [$];
    logic [31:0] stData [$];
    logic [31:0] lfsrState;
    logic        markerSeen;
    int          pcw;
    int          errors;
    int          checks;

    rvCore rvCore_inst (
        .clk(clk), .arstN(arstN), .instrAddr(instrAddr), .instr(instr),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataWe(dataWe),
        .dataRdata(dataRdata)
    );

    always #5 clk = ~clk;

    // Both memories answer in the same cycle, NOP while in reset
    assign instr     = arstN ? rom[instrAddr[11:2]] : nop;
    assign dataRdata = dmem[dataAddr[11:2]];

    // Executed PCs and committed stores
    always @(posedge clk) begin
        if (arstN) begin
            trace.push_back(instrAddr);
            if (dataWe) begin
                dmem[dataAddr[11:2]] <= dataWdata;
                if (dataAddr == markerAddr) begin
                    markerSeen <= 1'b1;
                end else begin
                    stAddr.push_back(dataAddr);
                    stData.push_back(dataWdata);
                end
            end
        end
    end

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    // RV32I arithmetic by funct3, alt selects SUB and SRA
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) begin
                    // Vacated top bits take the sign
                    return (a >> b[4:0]) | (a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 32'h0);
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            3'b111: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic int findPc(input logic [31:0] addr);
        for (int i = 0; i < trace.size(); i++) begin
            if (trace[i] == addr) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[pcw] = word;
        pcw++;
    endtask

    // LUI plus ADDI, upper part rounded for the signed low half
    task automatic loadImm(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] hi;
        hi = value + 32'h800;
        emit(encU(hi[31:12], rd, opLui));
        emit(encI(value[11:0], rd, 3'b000, rd, opImm));
    endtask

    task automatic storeWord(input logic [4:0] rs, input int off);
        emit(encS(off[11:0], rs, 5'd0));
    endtask

    task automatic endProgram();
        emit(encS(markerAddr[11:0], 5'd0, 5'd0));
        // Park on a self loop
        emit(encJ(21'd0, 5'd0));
    endtask

    task automatic clearMemories();
        for (int i = 0; i < 1024; i++) begin
            rom[i]  = nop;
            dmem[i] = (i * 32'h9E37_79B1) ^ 32'h5A5A_0000;
        end
    endtask

    task automatic compareWord(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic checkNextPc(input logic [31:0] at, input logic [31:0] exp);
        int idx;
        idx = findPc(at);
        checks++;
        if (idx < 0 || idx + 1 >= trace.size()) begin
            errors++;
            $display("Instruction at %h was never executed or had no successor", at);
        end else if (trace[idx + 1] !== exp) begin
            errors++;
            $display("Error: instrAddr after %h expected %h got %h", at, exp, trace[idx + 1]);
        end
    endtask

    // Core held in reset while the next program is written
    task automatic holdReset();
        @(posedge clk);
        arstN <= 1'b0;
        repeat (16) begin
            @(posedge clk);
            checks++;
            if (instrAddr !== `RESET_PC) begin
                errors++;
                $display("Error: instrAddr in reset expected %h got %h", `RESET_PC, instrAddr);
            end
            if (dataWe !== 1'b0) begin
                errors++;
                $display("Error: dataWe in reset expected %h got %h", 1'b0, dataWe);
            end
        end
        trace.delete();
        stAddr.delete();
        stData.delete();
        markerSeen = 1'b0;
        pcw = 0;
        clearMemories();
    endtask

    task automatic runProgram();
        int cycles;
        cycles = 0;
        arstN <= 1'b1;
        while (!markerSeen && cycles < runLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (!markerSeen) begin
            errors++;
            $display("Timeout: program never reached its final store");
        end
    endtask

    task automatic testReset();
        holdReset();
        emit(nop);
        endProgram();
        runProgram();
        if (trace.size() == 0) begin
            errors++;
            $display("No instruction was executed after reset");
        end else begin
            compareWord("instrAddr after reset", `RESET_PC, trace[0]);
        end
    endtask

    task automatic testAluOps();
        logic [31:0] pa [5];
        logic [31:0] pb [5];
        logic [31:0] expVal [96];
        logic [31:0] immVal;
        logic [11:0] imm12;
        logic [2:0]  f3;
        logic        alt;
        int          slot;
        pa[0] = randBits(32);
        pb[0] = randBits(32);
        pa[1] = 32'h8000_0000;
        pb[1] = 32'h7FFF_FFFF;
        pa[2] = 32'hFFFF_FFFF;
        pb[2] = 32'h0000_0001;
        pa[3] = randBits(32);
        pb[3] = 32'd0;
        pa[4] = randBits(32);
        pb[4] = 32'd31;
        holdReset();
        slot = 1;
        for (int p = 0; p < 5; p++) begin
            for (int op = 0; op < 10; op++) begin
                f3  = (op == 8) ? 3'b000 : (op == 9) ? 3'b101 : op[2:0];
                alt = (op >= 8);
                loadImm(5'd1, pa[p]);
                loadImm(5'd2, pb[p]);
                emit(encR(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd10));
                storeWord(5'd10, slot * 4);
                expVal[slot] = aluRef(f3, alt, pa[p], pb[p]);
                slot++;
                // Immediate form, there is no SUBI
                if (op != 8) begin
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        imm12  = {alt ? 7'h20 : 7'h00, pb[p][4:0]};
                        immVal = {27'b0, pb[p][4:0]};
                    end else begin
                        imm12  = pb[p][11:0];
                        immVal = {{20{imm12[11]}}, imm12};
                    end
                    emit(encI(imm12, 5'd1, f3, 5'd11, opImm));
                    storeWord(5'd11, slot * 4);
                    expVal[slot] = aluRef(f3, alt, pa[p], immVal);
                    slot++;
                end
            end
        end
        endProgram();
        runProgram();
        for (int s = 1; s < slot; s++) begin
            compareWord($sformatf("dataWdata slot %0d", s), expVal[s], dmem[s]);
        end
    endtask

    task automatic testLoadStore();
        logic [31:0] w0;
        logic [31:0] w1;
        w0 = randBits(32);
        w1 = randBits(32);
        holdReset();
        dmem[100] = w0;
        dmem[101] = w1;
        loadImm(5'd9, 32'd400);
        emit(encI(12'd0, 5'd9, 3'b010, 5'd6, opLoad));
        emit(encI(12'd4, 5'd9, 3'b010, 5'd7, opLoad));
        emit(encR(7'h00, 5'd7, 5'd6, 3'b000, 5'd8));
        emit(encS(12'd12, 5'd8, 5'd9));
        // Load into x0 must be dropped
        emit(encI(12'd0, 5'd9, 3'b010, 5'd0, opLoad));
        emit(encS(12'd16, 5'd0, 5'd9));
        endProgram();
        runProgram();
        checks++;
        if (stAddr.size() != 2) begin
            errors++;
            $display("Load/store program made %0d stores instead of 2", stAddr.size());
        end else begin
            compareWord("dataAddr of sum store", 32'd412, stAddr[0]);
            compareWord("dataWdata of sum store", w0 + w1, stData[0]);
            compareWord("dataAddr of x0 store", 32'd416, stAddr[1]);
            compareWord("dataWdata of x0 store", 32'd0, stData[1]);
        end
    endtask

    task automatic testBranches();
        logic [2:0]  f3List [6];
        logic [31:0] pa [3];
        logic [31:0] pb [3];
        logic [31:0] brPc [18];
        logic        brTaken [18];
        int          n;
        f3List = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        pa[0] = randBits(32);
        pb[0] = pa[0];
        pa[1] = 32'hFFFF_FFFF;
        pb[1] = 32'h0000_0001;
        pa[2] = 32'h0000_0001;
        pb[2] = 32'hFFFF_FFFF;
        holdReset();
        n = 0;
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 3; p++) begin
                loadImm(5'd1, pa[p]);
                loadImm(5'd2, pb[p]);
                brPc[n]    = pcw * 4;
                brTaken[n] = branchRef(f3List[f], pa[p], pb[p]);
                emit(encB(13'd8, 5'd2, 5'd1, f3List[f]));
                emit(nop);
                emit(nop);
                n++;
            end
        end
        endProgram();
        runProgram();
        for (int i = 0; i < 18; i++) begin
            checkNextPc(brPc[i], brPc[i] + (brTaken[i] ? 32'd8 : 32'd4));
        end
    endtask

    task automatic testJumps();
        logic [19:0] luiImm;
        logic [19:0] auiImm;
        logic [31:0] jalPc;
        logic [31:0] jalrPc;
        logic [31:0] auiPc;
        luiImm = randBits(20);
        auiImm = randBits(20);
        holdReset();
        jalPc = pcw * 4;
        emit(encJ(21'd12, 5'd11));
        emit(nop);
        emit(nop);
        storeWord(5'd11, 440);
        // Odd sum, target lands after bit 0 is dropped
        jalrPc = (pcw + 2) * 4;
        loadImm(5'd12, jalrPc + 32'd12);
        emit(encI(12'd1, 5'd12, 3'b000, 5'd13, opJalr));
        emit(nop);
        emit(nop);
        storeWord(5'd13, 444);
        emit(encU(luiImm, 5'd14, opLui));
        storeWord(5'd14, 448);
        auiPc = pcw * 4;
        emit(encU(auiImm, 5'd15, opAuipc));
        storeWord(5'd15, 452);
        endProgram();
        runProgram();
        checkNextPc(jalPc, jalPc + 32'd12);
        checkNextPc(jalrPc, jalrPc + 32'd12);
        compareWord("dataWdata JAL link", jalPc + 32'd4, dmem[110]);
        compareWord("dataWdata JALR link", jalrPc + 32'd4, dmem[111]);
        compareWord("dataWdata LUI", {luiImm, 12'b0}, dmem[112]);
        compareWord("dataWdata AUIPC", auiPc + {auiImm, 12'b0}, dmem[113]);
    endtask

    task automatic testIllegal();
        logic [31:0] illPc;
        logic [24:0] upperBits;
        holdReset();
        illPc = pcw * 4;
        upperBits = randBits(25);
        emit({upperBits, 7'h7F});
        endProgram();
        runProgram();
        checks++;
        if (stAddr.size() != 0) begin
            errors++;
            $display("Illegal opcode caused a store to %h", stAddr[0]);
        end
        checkNextPc(illPc, illPc + 32'd4);
    endtask

    initial begin
        clk        = 1'b0;
        arstN      = 1'b0;
        lfsrState  = 32'd9;
        markerSeen = 1'b0;
        pcw        = 0;
        errors     = 0;
        checks     = 0;
        clearMemories();
        testReset();
        testAluOps();
        testLoadStore();
        testBranches();
        testJumps();
        testIllegal();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
